/* verilog/motion_pkg.sv */
// motion_pkg : shared widths, register map and register bus structs for the motion system
package motion_pkg;

   typedef logic [31:0] reg_word_t;   // register data word
   typedef logic [7:0]  reg_addr_t;   // {unit, register}
   typedef logic [3:0]  unit_id_t;    // upper address nibble
   typedef logic [7:0]  up_byte_t;    // uP port byte

   localparam int BYTES_PER_WORD = 4;  // data bytes per uP transaction

   // encoder registers
   localparam logic [3:0] QE_POSITION = 4'd0;   // r/w, write presets count
   localparam logic [3:0] QE_INDEX    = 4'd1;   // ro, position at last index
   localparam logic [3:0] QE_STATUS   = 4'd2;   // ro, {illegal, index seen, fwd}

   // pwm registers
   localparam logic [3:0] PWM_PERIOD  = 4'd0;
   localparam logic [3:0] PWM_DUTY    = 4'd1;
   localparam logic [3:0] PWM_CONTROL = 4'd2;   // {reverse, enable}

   // bridge to slaves, valid for one cycle
   typedef struct packed {
      logic      valid;
      logic      write;
      reg_addr_t addr;
      reg_word_t wdata;
   } reg_cmd_t;

   // slave to bridge, zero unless read in the previous cycle
   typedef struct packed {
      reg_word_t rdata;
   } reg_rsp_t;

   typedef enum logic [2:0] {
      IDLE,
      ADDR_REQ,    // wait for address byte
      ADDR_REL,    // wait for handshake_1 to drop
      ACCESS,      // register bus strobe plus response cycle
      DATA_REQ,
      DATA_REL,
      DONE         // ack until start drops
   } bridge_state_t;

endpackage

/* verilog/up_bridge.sv */
// up_bridge : byte-wide four-phase uP port to 32-bit register bus master
`timescale 1ns/1ps

module up_bridge #(
   parameter int NUM_SLAVES = 4
) (
   input  logic                                    CLOCK_50,
   input  logic                                    reset,
   input  logic                                    up_start,        // async
   input  logic                                    up_rw,           // async, 1 = read
   input  logic                                    up_handshake_1,  // async
   input  motion_pkg::up_byte_t                    up_data_in,
   output logic                                    up_ack,
   output logic                                    up_handshake_2,
   output motion_pkg::up_byte_t                    up_data_out,
   output logic                                    up_data_oe,
   output motion_pkg::reg_cmd_t                    cmd,
   input  motion_pkg::reg_rsp_t [NUM_SLAVES-1:0]   rsp
);

   localparam logic [1:0] LAST_BYTE = 2'(motion_pkg::BYTES_PER_WORD - 1);

   logic [1:0] start_sync, rw_sync, hs1_sync;   // two flop synchronizers
   logic       start_s, hs1_s;

   motion_pkg::bridge_state_t state;
   logic                      rw_q;        // latched at start of transaction
   logic [1:0]                byte_cnt;    // data byte number
   logic                      issued;      // strobe cycle done, response next
   motion_pkg::reg_addr_t     addr_q;
   motion_pkg::reg_word_t     data_word;   // shifts one byte per handshake
   motion_pkg::reg_word_t     rsp_word;

   assign start_s = start_sync[1];
   assign hs1_s   = hs1_sync[1];

   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         start_sync <= '0;
         rw_sync    <= '0;
         hs1_sync   <= '0;
      end else begin
         start_sync <= {start_sync[0], up_start};
         rw_sync    <= {rw_sync[0], up_rw};
         hs1_sync   <= {hs1_sync[0], up_handshake_1};
      end
   end

   // OR of all slave responses, unaddressed slaves return zero
   always_comb begin
      rsp_word = '0;
      for (int i = 0; i < NUM_SLAVES; i++) begin
         rsp_word = rsp_word | rsp[i].rdata;
      end
   end

   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         state          <= motion_pkg::IDLE;
         up_ack         <= 1'b0;
         up_handshake_2 <= 1'b0;
         rw_q           <= 1'b0;
         byte_cnt       <= '0;
         issued         <= 1'b0;
      end else begin
         unique case (state)
            motion_pkg::IDLE: if (start_s) begin
               rw_q     <= rw_sync[1];
               byte_cnt <= '0;
               state    <= motion_pkg::ADDR_REQ;
            end
            motion_pkg::ADDR_REQ: if (hs1_s) begin
               up_handshake_2 <= 1'b1;
               state          <= motion_pkg::ADDR_REL;
            end
            motion_pkg::ADDR_REL: if (!hs1_s) begin
               up_handshake_2 <= 1'b0;
               state          <= rw_q ? motion_pkg::ACCESS : motion_pkg::DATA_REQ;  // read early
            end
            motion_pkg::ACCESS: begin
               issued <= !issued;                   // strobe, then response cycle
               if (issued) begin
                  state <= rw_q ? motion_pkg::DATA_REQ : motion_pkg::DONE;
               end
            end
            motion_pkg::DATA_REQ: if (hs1_s) begin
               up_handshake_2 <= 1'b1;
               state          <= motion_pkg::DATA_REL;
            end
            motion_pkg::DATA_REL: if (!hs1_s) begin
               up_handshake_2 <= 1'b0;
               byte_cnt       <= byte_cnt + 2'd1;
               if (byte_cnt == LAST_BYTE) begin
                  state <= rw_q ? motion_pkg::DONE : motion_pkg::ACCESS;  // write after byte 4
               end else begin
                  state <= motion_pkg::DATA_REQ;
               end
            end
            motion_pkg::DONE: begin
               up_ack <= start_s;                   // drop once host releases start
               if (!start_s) state <= motion_pkg::IDLE;
            end
            default: state <= motion_pkg::IDLE;
         endcase
      end
   end

   // address and data payload
   always_ff @(posedge CLOCK_50) begin
      if (state == motion_pkg::ADDR_REQ && hs1_s) begin
         addr_q <= up_data_in;
      end
      if (state == motion_pkg::DATA_REQ && hs1_s && !rw_q) begin
         data_word <= {up_data_in, data_word[31:8]};     // lsb first, fills from top
      end else if (state == motion_pkg::DATA_REL && !hs1_s && rw_q) begin
         data_word <= {8'h00, data_word[31:8]};          // next read byte down
      end else if (state == motion_pkg::ACCESS && issued && rw_q) begin
         data_word <= rsp_word;                          // one cycle read latency
      end
   end

   always_comb begin
      cmd.valid = (state == motion_pkg::ACCESS) && !issued;
      cmd.write = !rw_q;
      cmd.addr  = addr_q;
      cmd.wdata = data_word;
   end

   assign up_data_out = data_word[7:0];
   assign up_data_oe  = rw_q && (state == motion_pkg::DATA_REQ ||
                                 state == motion_pkg::DATA_REL ||
                                 state == motion_pkg::DONE);

endmodule

/* verilog/quad_encoder.sv */
// quad_encoder : 4x quadrature decoder with position, index latch and status registers
`timescale 1ns/1ps

module quad_encoder #(
   parameter motion_pkg::unit_id_t UNIT = '0
) (
   input  logic                 CLOCK_50,
   input  logic                 reset,
   input  motion_pkg::reg_cmd_t cmd,
   output motion_pkg::reg_rsp_t rsp,
   input  logic                 quad_a,      // async
   input  logic                 quad_b,      // async
   input  logic                 quad_i       // async index
);

   logic [1:0] a_sync, b_sync, i_sync;
   logic [1:0] ab_bin, ab_prev_bin;   // gray phase as binary 0..3
   logic [1:0] step;                  // 1 fwd, 3 rev, 2 illegal
   logic       i_prev, index_edge;

   motion_pkg::reg_word_t position, index_pos, rd_data;
   logic                  dir_fwd, index_seen, illegal;
   logic                  sel, wr_pos, rd_any, rd_status;

   // gray 00,01,11,10 maps to 0,1,2,3
   assign ab_bin     = {a_sync[1], a_sync[1] ^ b_sync[1]};
   assign step       = ab_bin - ab_prev_bin;
   assign index_edge = i_sync[1] & ~i_prev;

   assign sel       = cmd.valid && (cmd.addr[7:4] == UNIT);
   assign wr_pos    = sel && cmd.write && (cmd.addr[3:0] == motion_pkg::QE_POSITION);
   assign rd_any    = sel && !cmd.write;
   assign rd_status = rd_any && (cmd.addr[3:0] == motion_pkg::QE_STATUS);

   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         a_sync <= '0;
         b_sync <= '0;
         i_sync <= '0;
      end else begin
         a_sync <= {a_sync[0], quad_a};
         b_sync <= {b_sync[0], quad_b};
         i_sync <= {i_sync[0], quad_i};
      end
   end

   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         ab_prev_bin <= '0;
         i_prev      <= 1'b0;
         position    <= '0;
         index_pos   <= '0;
         dir_fwd     <= 1'b0;
         index_seen  <= 1'b0;
         illegal     <= 1'b0;
      end else begin
         ab_prev_bin <= ab_bin;
         i_prev      <= i_sync[1];
         if (wr_pos) position <= cmd.wdata;           // preset wins over a count
         else if (step == 2'd1) position <= position + 32'd1;
         else if (step == 2'd3) position <= position - 32'd1;
         case (step)
            2'd1:    dir_fwd <= 1'b1;
            2'd3:    dir_fwd <= 1'b0;
            2'd2:    illegal <= 1'b1;                 // both lines moved, sticky
            default: ;
         endcase
         if (index_edge) begin
            index_pos  <= position;
            index_seen <= 1'b1;                       // set beats clear-on-read
         end else if (rd_status) begin
            index_seen <= 1'b0;
         end
      end
   end

   always_comb begin
      unique case (cmd.addr[3:0])
         motion_pkg::QE_POSITION: rd_data = position;
         motion_pkg::QE_INDEX:    rd_data = index_pos;
         motion_pkg::QE_STATUS:   rd_data = {29'd0, illegal, index_seen, dir_fwd};
         default:                 rd_data = '0;
      endcase
   end

   always_ff @(posedge CLOCK_50) begin
      if (reset) rsp.rdata <= '0;
      else       rsp.rdata <= rd_any ? rd_data : '0;   // zero when not read
   end

endmodule

/* verilog/pwm_channel.sv */
// pwm_channel : PWM generator with shadowed period and duty, steered onto an H-bridge
`timescale 1ns/1ps

module pwm_channel #(
   parameter motion_pkg::unit_id_t UNIT = '0
) (
   input  logic                 CLOCK_50,
   input  logic                 reset,
   input  motion_pkg::reg_cmd_t cmd,
   output motion_pkg::reg_rsp_t rsp,
   output logic                 pwm_out,
   output logic                 h_bridge_1,
   output logic                 h_bridge_2
);

   motion_pkg::reg_word_t period, duty, control;   // bus visible
   motion_pkg::reg_word_t period_act, duty_act;    // loaded at wrap
   motion_pkg::reg_word_t counter, rd_data;
   logic                  sel, wr, rd, wrap, pwm_next;

   assign sel = cmd.valid && (cmd.addr[7:4] == UNIT);
   assign wr  = sel && cmd.write;
   assign rd  = sel && !cmd.write;

   // zero period wraps every cycle so new values load at once
   assign wrap     = (period_act == '0) || (counter >= period_act - 32'd1);
   assign pwm_next = control[0] && (period_act != '0) && (counter < duty_act);

   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         period  <= '0;
         duty    <= '0;
         control <= '0;
      end else if (wr) begin
         case (cmd.addr[3:0])
            motion_pkg::PWM_PERIOD:  period  <= cmd.wdata;
            motion_pkg::PWM_DUTY:    duty    <= cmd.wdata;
            motion_pkg::PWM_CONTROL: control <= cmd.wdata;
            default: ;
         endcase
      end
   end

   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         counter    <= '0;
         period_act <= '0;
         duty_act   <= '0;
      end else if (wrap) begin
         counter    <= '0;
         period_act <= period;
         duty_act   <= duty;
      end else begin
         counter <= counter + 32'd1;
      end
   end

   // registered outputs, unused leg held low
   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         pwm_out    <= 1'b0;
         h_bridge_1 <= 1'b0;
         h_bridge_2 <= 1'b0;
      end else begin
         pwm_out    <= pwm_next;
         h_bridge_1 <= pwm_next && !control[1];   // forward
         h_bridge_2 <= pwm_next && control[1];    // reverse
      end
   end

   always_comb begin
      unique case (cmd.addr[3:0])
         motion_pkg::PWM_PERIOD:  rd_data = period;
         motion_pkg::PWM_DUTY:    rd_data = duty;
         motion_pkg::PWM_CONTROL: rd_data = control;
         default:                 rd_data = '0;
      endcase
   end

   always_ff @(posedge CLOCK_50) begin
      if (reset) rsp.rdata <= '0;
      else       rsp.rdata <= rd ? rd_data : '0;
   end

endmodule

/* verilog/motion_system.sv */
// motion_system : uP bridge with quadrature encoder and PWM slaves on the register bus
`timescale 1ns/1ps

module motion_system #(
   parameter int NUM_QE  = 2,
   parameter int NUM_PWM = 2
) (
   input  logic                 CLOCK_50,
   input  logic                 reset,
   input  logic                 up_start,
   input  logic                 up_rw,            // 1 = read
   input  logic                 up_handshake_1,
   input  motion_pkg::up_byte_t up_data_in,
   output logic                 up_ack,
   output logic                 up_handshake_2,
   output motion_pkg::up_byte_t up_data_out,
   output logic                 up_data_oe,       // board wrapper builds the inout
   input  logic [NUM_QE-1:0]    quadrature_a,
   input  logic [NUM_QE-1:0]    quadrature_b,
   input  logic [NUM_QE-1:0]    quadrature_i,
   output logic [NUM_PWM-1:0]   pwm_out,
   output logic [NUM_PWM-1:0]   h_bridge_1,
   output logic [NUM_PWM-1:0]   h_bridge_2
);

   localparam int NUM_SLAVES = NUM_QE + NUM_PWM;

   motion_pkg::reg_cmd_t                  cmd;
   motion_pkg::reg_rsp_t [NUM_SLAVES-1:0] rsp;   // encoders low, pwm above

   up_bridge #(.NUM_SLAVES(NUM_SLAVES)) bridge (
      .CLOCK_50       (CLOCK_50),
      .reset          (reset),
      .up_start       (up_start),
      .up_rw          (up_rw),
      .up_handshake_1 (up_handshake_1),
      .up_data_in     (up_data_in),
      .up_ack         (up_ack),
      .up_handshake_2 (up_handshake_2),
      .up_data_out    (up_data_out),
      .up_data_oe     (up_data_oe),
      .cmd            (cmd),
      .rsp            (rsp)
   );

   // encoders on units 0 .. NUM_QE-1
   for (genvar q = 0; q < NUM_QE; q++) begin : g_qe
      quad_encoder #(.UNIT(motion_pkg::unit_id_t'(q))) qe_ch (
         .CLOCK_50 (CLOCK_50),
         .reset    (reset),
         .cmd      (cmd),
         .rsp      (rsp[q]),
         .quad_a   (quadrature_a[q]),
         .quad_b   (quadrature_b[q]),
         .quad_i   (quadrature_i[q])
      );
   end

   // pwm channels follow the encoders
   for (genvar p = 0; p < NUM_PWM; p++) begin : g_pwm
      pwm_channel #(.UNIT(motion_pkg::unit_id_t'(NUM_QE + p))) pwm_ch (
         .CLOCK_50   (CLOCK_50),
         .reset      (reset),
         .cmd        (cmd),
         .rsp        (rsp[NUM_QE + p]),
         .pwm_out    (pwm_out[p]),
         .h_bridge_1 (h_bridge_1[p]),
         .h_bridge_2 (h_bridge_2[p])
      );
   end

endmodule

/* dv/motion_system_tb.sv */
// motion_system_tb drives the uP port and encoder inputs and checks registers and PWM outputs
`timescale 1ns/1ps

module motion_system_tb;

   localparam int NUM_QE    = 2;
   localparam int NUM_PWM   = 2;
   localparam int TIMEOUT   = 200;   // cycles allowed per wait
   localparam int FWD_STEPS = 6;
   localparam int REV_STEPS = 2;
   localparam int PWM_N     = 7;     // test period
   localparam int PWM_D     = 3;     // test duty below PWM_N

   logic                 clock = 1'b0;
   logic                 reset;
   logic                 up_start, up_rw, up_handshake_1;
   motion_pkg::up_byte_t up_data_in, up_data_out;
   logic                 up_ack, up_handshake_2, up_data_oe;
   logic [NUM_QE-1:0]    quadrature_a, quadrature_b, quadrature_i;
   logic [NUM_PWM-1:0]   pwm_out, h_bridge_1, h_bridge_2;

   logic [15:0] lfsr = 16'd78;     // galois state
   logic [1:0]  qe_phase;          // encoder 0 gray phase in binary
   int          pwm_old [NUM_PWM]; // period left active by the loopback test

   motion_system #(.NUM_QE(NUM_QE), .NUM_PWM(NUM_PWM)) UUT (
      .CLOCK_50       (clock),
      .reset          (reset),
      .up_start       (up_start),
      .up_rw          (up_rw),
      .up_handshake_1 (up_handshake_1),
      .up_data_in     (up_data_in),
      .up_ack         (up_ack),
      .up_handshake_2 (up_handshake_2),
      .up_data_out    (up_data_out),
      .up_data_oe     (up_data_oe),
      .quadrature_a   (quadrature_a),
      .quadrature_b   (quadrature_b),
      .quadrature_i   (quadrature_i),
      .pwm_out        (pwm_out),
      .h_bridge_1     (h_bridge_1),
      .h_bridge_2     (h_bridge_2)
   );

   always #20 clock = ~clock;   // 40 ns period

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_eq(input string name, input motion_pkg::reg_word_t exp,
                           input motion_pkg::reg_word_t act);
      assert (act === exp) else
         abort_run($sformatf("FAIL t=%0t %s expected 0x%h actual 0x%h", $time, name, exp, act));
   endtask

   // four-phase order on the uP port, seen at the moment handshake_2 moves
   always @(posedge up_handshake_2) begin
      if (!reset) begin
         assert (up_handshake_1)
            else abort_run("handshake_2 rose while handshake_1 was low");
      end
   end

   always @(negedge up_handshake_2) begin
      if (!reset) begin
         assert (!up_handshake_1)
            else abort_run("handshake_2 fell while handshake_1 was high");
      end
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // maximal 16 bit taps
   endfunction

   task automatic rand_bits(input int nbits, output motion_pkg::reg_word_t w);
      w = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = lfsr_next(lfsr);   // one step per bit
         w[i] = lfsr[0];
      end
   endtask

   function automatic motion_pkg::reg_addr_t make_addr(input int unit, input logic [3:0] regnum);
      make_addr = {unit[3:0], regnum};
   endfunction

   // all waits start and end at posedge + 2 ns
   task automatic wait_hs2(input logic level, input string what);
      int n;
      n = 0;
      while (up_handshake_2 !== level) begin
         @(posedge clock);
         #2;
         n++;
         if (n > TIMEOUT) abort_run(what);
      end
   endtask

   task automatic wait_ack(input logic level, input string what);
      int n;
      n = 0;
      while (up_ack !== level) begin
         @(posedge clock);
         #2;
         n++;
         if (n > TIMEOUT) abort_run(what);
      end
   endtask

   // one byte in four phases
   task automatic xfer_byte(input motion_pkg::up_byte_t wr_byte, input logic data_byte,
                            output motion_pkg::up_byte_t rd_byte);
      up_data_in     = wr_byte;
      up_handshake_1 = 1'b1;
      wait_hs2(1'b1, "handshake_2 did not rise after handshake_1 went high");
      check_eq("up_data_oe", 32'(up_rw && data_byte), 32'(up_data_oe));   // only read data
      rd_byte        = up_data_out;
      up_handshake_1 = 1'b0;
      wait_hs2(1'b0, "handshake_2 did not fall after handshake_1 went low");
   endtask

   task automatic bus_access(input logic rw, input motion_pkg::reg_addr_t addr,
                             input motion_pkg::reg_word_t wdata,
                             output motion_pkg::reg_word_t rdata);
      motion_pkg::up_byte_t b;
      rdata    = '0;
      up_rw    = rw;
      up_start = 1'b1;
      xfer_byte(addr, 1'b0, b);
      for (int i = 0; i < motion_pkg::BYTES_PER_WORD; i++) begin
         xfer_byte(wdata[8*i +: 8], 1'b1, b);   // lsb first
         rdata[8*i +: 8] = b;
      end
      wait_ack(1'b1, "up_ack did not rise after the last byte");
      up_start = 1'b0;
      wait_ack(1'b0, "up_ack did not fall after up_start dropped");
   endtask

   task automatic reg_write(input motion_pkg::reg_addr_t addr, input motion_pkg::reg_word_t data);
      motion_pkg::reg_word_t ignored;
      bus_access(1'b0, addr, data, ignored);
   endtask

   task automatic reg_read(input motion_pkg::reg_addr_t addr, output motion_pkg::reg_word_t data);
      bus_access(1'b1, addr, 32'd0, data);
   endtask

   // gray step on encoder 0 held long enough to be counted
   task automatic quad_move(input logic [1:0] delta);
      qe_phase        = qe_phase + delta;
      quadrature_a[0] = qe_phase[1];
      quadrature_b[0] = qe_phase[1] ^ qe_phase[0];
      repeat (4) @(posedge clock);
      #2;
   endtask

   task automatic measure_pwm(input int ch, input logic rev, output int high_cnt);
      high_cnt = 0;
      for (int c = 0; c < PWM_N; c++) begin
         @(posedge clock);
         #2;
         if (pwm_out[ch]) high_cnt++;
         check_eq("h_bridge_1", 32'(pwm_out[ch] && !rev), 32'(h_bridge_1[ch]));
         check_eq("h_bridge_2", 32'(pwm_out[ch] && rev), 32'(h_bridge_2[ch]));
      end
   endtask

   initial begin
      motion_pkg::reg_word_t p, wr, rd, exp_pos;
      int                    cnt;
      reset          = 1'b1;
      up_start       = 1'b0;
      up_rw          = 1'b0;
      up_handshake_1 = 1'b0;
      up_data_in     = '0;
      quadrature_a   = '0;
      quadrature_b   = '0;
      quadrature_i   = '0;
      qe_phase       = '0;
      repeat (2) @(posedge clock);
      #2;
      reset = 1'b0;

      check_eq("up_ack", 32'd0, 32'(up_ack));
      check_eq("up_handshake_2", 32'd0, 32'(up_handshake_2));
      check_eq("up_data_oe", 32'd0, 32'(up_data_oe));
      check_eq("pwm_out", 32'd0, 32'(pwm_out));
      check_eq("h_bridge_1", 32'd0, 32'(h_bridge_1));
      check_eq("h_bridge_2", 32'd0, 32'(h_bridge_2));
      reg_read(make_addr(0, motion_pkg::QE_POSITION), rd);
      check_eq("qe position after reset", 32'd0, rd);
      reg_read(make_addr(NUM_QE, motion_pkg::PWM_PERIOD), rd);
      check_eq("pwm period after reset", 32'd0, rd);

      // loopback with the period kept to 8 bits so the next wrap comes soon
      for (int ch = 0; ch < NUM_PWM; ch++) begin
         rand_bits(8, wr);
         pwm_old[ch] = int'(wr);
         reg_write(make_addr(NUM_QE + ch, motion_pkg::PWM_PERIOD), wr);
         reg_read(make_addr(NUM_QE + ch, motion_pkg::PWM_PERIOD), rd);
         check_eq("pwm period", wr, rd);
         rand_bits(32, wr);
         reg_write(make_addr(NUM_QE + ch, motion_pkg::PWM_DUTY), wr);
         reg_read(make_addr(NUM_QE + ch, motion_pkg::PWM_DUTY), rd);
         check_eq("pwm duty", wr, rd);
      end
      reg_read(make_addr(7, motion_pkg::QE_POSITION), rd);
      check_eq("unmapped read", 32'd0, rd);

      // counting from a random preset
      rand_bits(32, p);
      reg_write(make_addr(0, motion_pkg::QE_POSITION), p);
      reg_read(make_addr(0, motion_pkg::QE_POSITION), rd);
      check_eq("qe position preset", p, rd);
      repeat (FWD_STEPS) quad_move(2'd1);
      reg_read(make_addr(0, motion_pkg::QE_STATUS), rd);
      check_eq("qe status after forward", 32'h1, rd);
      repeat (REV_STEPS) quad_move(2'd3);
      exp_pos = p + 32'(FWD_STEPS) - 32'(REV_STEPS);
      reg_read(make_addr(0, motion_pkg::QE_POSITION), rd);
      check_eq("qe position", exp_pos, rd);
      reg_read(make_addr(0, motion_pkg::QE_STATUS), rd);
      check_eq("qe status after reverse", 32'h0, rd);

      // index latch and its flag clearing on read
      quadrature_i[0] = 1'b1;
      repeat (4) @(posedge clock);
      #2;
      quadrature_i[0] = 1'b0;
      repeat (4) @(posedge clock);
      #2;
      reg_read(make_addr(0, motion_pkg::QE_INDEX), rd);
      check_eq("qe index", exp_pos, rd);
      reg_read(make_addr(0, motion_pkg::QE_STATUS), rd);
      check_eq("qe status first read", 32'h2, rd);
      reg_read(make_addr(0, motion_pkg::QE_STATUS), rd);
      check_eq("qe status second read", 32'h0, rd);

      quad_move(2'd2);   // a and b together
      reg_read(make_addr(0, motion_pkg::QE_STATUS), rd);
      check_eq("qe status illegal", 32'h4, rd);
      reg_read(make_addr(0, motion_pkg::QE_POSITION), rd);
      check_eq("qe position after illegal", exp_pos, rd);

      for (int ch = 0; ch < NUM_PWM; ch++) begin
         reg_write(make_addr(NUM_QE + ch, motion_pkg::PWM_DUTY), 32'(PWM_D));
         reg_write(make_addr(NUM_QE + ch, motion_pkg::PWM_PERIOD), 32'(PWM_N));
         reg_write(make_addr(NUM_QE + ch, motion_pkg::PWM_CONTROL), 32'h1);
         repeat (pwm_old[ch] + 2 * PWM_N + 4) @(posedge clock);   // old wrap and a full period
         #2;
         measure_pwm(ch, 1'b0, cnt);
         check_eq("pwm_out high cycles forward", 32'(PWM_D), 32'(cnt));
         reg_write(make_addr(NUM_QE + ch, motion_pkg::PWM_CONTROL), 32'h3);
         measure_pwm(ch, 1'b1, cnt);
         check_eq("pwm_out high cycles reverse", 32'(PWM_D), 32'(cnt));
         reg_write(make_addr(NUM_QE + ch, motion_pkg::PWM_CONTROL), 32'h0);
         measure_pwm(ch, 1'b0, cnt);
         check_eq("pwm_out high cycles disabled", 32'd0, 32'(cnt));
      end

      $display("Finished with no errors");
      $finish;
   end

endmodule

/* verilog.f */
verilog/motion_pkg.sv
verilog/up_bridge.sv
verilog/quad_encoder.sv
verilog/pwm_channel.sv
verilog/motion_system.sv
dv/motion_system_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the motion_system testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f \
   --top-module motion_system_tb -o motion_system_sim
./obj_dir/motion_system_sim
